// ==== flist.f ====
gb_map_pkg.sv
gb_io_pkg.sv
gb_bus_decode.sv
gb_irq_ctrl.sv
gb_joypad.sv
gb_serial.sv
gb_ram_ctrl.sv
gb_io_top.sv
gb_io_sva.sv
tb_gb_io.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
LINTFLAGS = --lint-only --timing --assert
TOP       = tb_gb_io
FLIST     = flist.f
OBJ_DIR   = obj_dir
PASS_MSG  = ALL CHECKS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== tb_gb_io.sv ====
// ------------------------------------------------------------------------
// testbench for the console I/O subsystem: ram banking, zero page, joypad,
// interrupts, serial and boot register, driven over the cpu bus port
// ------------------------------------------------------------------------
`timescale 1ns/100ps

module tb_gb_io;
	import gb_map_pkg::*;
	import gb_io_pkg::*;

	localparam logic [31:0] SEED = 32'd57;
	localparam int READ_TIMEOUT  = 8;    // cycles to rdata_valid
	localparam int SER_POLLS     = 4000; // ~2 cycles per poll, transfer ~4100

	logic       clk_cpu;
	logic       reset;
	cpu_bus_t   bus;
	logic       irq_ack;
	logic [7:0] joystick;
	logic       isgbc;
	logic       fast_boot;
	irq_bits_t  ext_irq;
	data_t      rdata;
	logic       rdata_valid;
	logic       irq;
	data_t      irq_vec;

	logic [31:0] rng;
	int          checks;
	int          errors;
	int          tests;
	int          err_at_start; // error count when the test began
	data_t       wram_exp [16];
	data_t       zp_exp [ZP_DEPTH];

	gb_io_top uut (
		.clk_cpu     (clk_cpu),
		.reset       (reset),
		.bus         (bus),
		.irq_ack     (irq_ack),
		.joystick    (joystick),
		.isgbc       (isgbc),
		.fast_boot   (fast_boot),
		.ext_irq     (ext_irq),
		.rdata       (rdata),
		.rdata_valid (rdata_valid),
		.irq         (irq),
		.irq_vec     (irq_vec)
	);

	always #4 clk_cpu = ~clk_cpu; // 8 ns period

	// ------------------------------------------------------------------------
	// helpers
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic next_byte(output data_t b);
		rng = xorshift32(rng);
		b   = rng[15:8];
	endtask

	// P1 value: 11, select bits, then the two inverted groups ANDed
	function automatic data_t joy_expect(input logic [1:0] p1, input logic [7:0] keys);
		logic [3:0] dpad;
		logic [3:0] btn;
		dpad = p1[0] ? 4'hF : ~keys[3:0]; // P14 low selects the d-pad
		btn  = p1[1] ? 4'hF : ~keys[7:4];
		return {2'b11, p1, dpad & btn};
	endfunction

	function automatic int lowest_set(input irq_bits_t b);
		for (int i = 0; i < 5; i++)
			if (b[i])
				return i;
		return -1;
	endfunction

	task automatic bus_write(input addr_t a, input data_t d);
		@(posedge clk_cpu);
		bus <= '{addr: a, wdata: d, rd: 1'b0, wr: 1'b1};
		@(posedge clk_cpu);
		bus <= '{addr: a, wdata: d, rd: 1'b0, wr: 1'b0};
	endtask

	// one read, waits for rdata_valid and samples at the falling edge
	task automatic bus_read(input addr_t a, output data_t d);
		int n;
		@(posedge clk_cpu);
		bus <= '{addr: a, wdata: 8'h00, rd: 1'b1, wr: 1'b0};
		@(posedge clk_cpu);
		bus <= '{addr: a, wdata: 8'h00, rd: 1'b0, wr: 1'b0}; // address held
		n = 0;
		do begin
			@(negedge clk_cpu);
			n++;
		end while (!rdata_valid && n < READ_TIMEOUT);
		if (!rdata_valid) begin
			$display("read of %h timed out, rdata_valid never came", a);
			errors++;
		end
		d = rdata;
	endtask

	task automatic check_byte(input string what, input data_t got, input data_t exp);
		checks++;
		assert (got === exp)
		else begin
			$display("mismatch %s: got %h, expected %h", what, got, exp);
			errors++;
		end
	endtask

	task automatic read_check(input string what, input addr_t a, input data_t exp);
		data_t d;
		bus_read(a, d);
		check_byte(what, d, exp);
	endtask

	task automatic check_true(input logic cond, input string msg);
		checks++;
		assert (cond)
		else begin
			$display("%s", msg);
			errors++;
		end
	endtask

	task automatic end_test(input string name);
		tests++;
		if (errors == err_at_start)
			$display("test %0d %s: ok", tests, name);
		else
			$display("test %0d %s: %0d errors", tests, name, errors - err_at_start);
		err_at_start = errors;
	endtask

	// ------------------------------------------------------------------------
	// stimulus
	initial begin
		data_t     d;
		data_t     d2;
		int        n;
		int        idx;
		irq_bits_t exp_if;  // flags still pending, tb side
		logic [1:0] p;

		clk_cpu   = 1'b0;
		reset     = 1'b1;
		bus       = '0;
		irq_ack   = 1'b0;
		joystick  = 8'h00;
		isgbc     = 1'b1;  // colour mode
		fast_boot = 1'b1;
		ext_irq   = '0;
		rng       = SEED;
		checks    = 0;
		errors    = 0;
		tests     = 0;
		err_at_start = 0;
		repeat (4) @(posedge clk_cpu);
		reset <= 1'b0;

		// work ram, bank 0 window then two switched banks
		for (int i = 0; i < 16; i++) begin
			next_byte(wram_exp[i]);
			bus_write(ADDR_WRAM_BASE + addr_t'(i * 257), wram_exp[i]);
		end
		for (int i = 0; i < 16; i++)
			read_check("wram bank 0", ADDR_WRAM_BASE + addr_t'(i * 257), wram_exp[i]);
		next_byte(d);
		next_byte(d2);
		bus_write(ADDR_SVBK, 8'h02);
		bus_write(16'hD123, d);
		bus_write(ADDR_SVBK, 8'h05);
		bus_write(16'hD123, d2);
		read_check("wram bank 5", 16'hD123, d2);
		bus_write(ADDR_SVBK, 8'h02);
		read_check("wram bank 2", 16'hD123, d);
		read_check("SVBK", ADDR_SVBK, 8'hFA);
		bus_write(ADDR_SVBK, 8'h00); // 0 stores 1
		read_check("SVBK after 0", ADDR_SVBK, 8'hF9);
		@(posedge clk_cpu);
		isgbc <= 1'b0;
		read_check("SVBK classic", ADDR_SVBK, 8'hFF);
		@(posedge clk_cpu);
		isgbc <= 1'b1;
		end_test("wram banking");

		// zero page, whole window
		for (int i = 0; i < ZP_DEPTH; i++) begin
			next_byte(zp_exp[i]);
			bus_write(ADDR_ZP_BASE + addr_t'(i), zp_exp[i]);
		end
		for (int i = 0; i < ZP_DEPTH; i++)
			read_check("zpram", ADDR_ZP_BASE + addr_t'(i), zp_exp[i]);
		read_check("rom 0000", 16'h0000, 8'hFF);
		read_check("cart ram A000", 16'hA000, 8'hFF);
		read_check("unmapped FF03", 16'hFF03, 8'hFF);
		end_test("zero page and open bus");

		// joypad, every select pattern with random keys
		for (int s = 0; s < 4; s++) begin
			p = 2'(s);
			next_byte(d);
			@(posedge clk_cpu);
			joystick <= d;
			bus_write(ADDR_JOY, {2'b00, p, 4'h0});
			read_check("P1", ADDR_JOY, joy_expect(p, d));
		end
		@(posedge clk_cpu);
		joystick <= 8'h00;
		bus_write(ADDR_JOY, 8'h20);     // d-pad group only
		repeat (4) @(posedge clk_cpu);  // let the synchroniser settle
		bus_write(ADDR_IF, 8'h00);
		@(posedge clk_cpu);
		joystick <= 8'h01;              // right pressed
		n = 0;
		d = 8'h00;
		while (!d[IRQ_JOYPAD] && n < 10) begin
			bus_read(ADDR_IF, d);
			n++;
		end
		check_true(d[IRQ_JOYPAD], "joypad press did not set IF bit 4");
		check_byte("IF after press", d, 8'hF0);
		@(posedge clk_cpu);
		joystick <= 8'h00;  // release, rising lines only
		end_test("joypad");

		// interrupts, drain in priority order
		bus_write(ADDR_IE, 8'h1F);
		bus_write(ADDR_IF, 8'h18);  // serial and joypad
		@(posedge clk_cpu);
		ext_irq <= 5'b00101;        // vblank and timer
		@(posedge clk_cpu);
		ext_irq <= '0;
		exp_if = 5'b11101;
		n = 0;
		do begin
			@(negedge clk_cpu);
			n++;
		end while (!irq && n < 10);
		check_true(irq, "irq did not rise with enabled flags pending");
		while (exp_if != '0) begin
			idx = lowest_set(exp_if);
			@(negedge clk_cpu);
			check_byte("irq_vec", irq_vec, 8'h40 + 8'(idx * 8));
			check_true(irq, "irq low while flags are pending");
			@(posedge clk_cpu);
			irq_ack <= 1'b1;
			@(posedge clk_cpu);
			irq_ack <= 1'b0;
			exp_if[idx] = 1'b0;
		end
		@(negedge clk_cpu);
		check_byte("irq_vec idle", irq_vec, 8'h55);
		check_true(!irq, "irq still high after every flag was acknowledged");
		read_check("IF drained", ADDR_IF, 8'hE0);
		read_check("IE", ADDR_IE, 8'h1F);
		end_test("interrupts");

		// serial, internal clock transfer
		bus_write(ADDR_IF, 8'h00);
		bus_write(ADDR_SC, 8'h81);
		bus_read(ADDR_SC, d);
		check_byte("SC running", d, 8'hFF);
		n = 0;
		while (d[7] && n < SER_POLLS) begin
			bus_read(ADDR_SC, d);
			n++;
		end
		if (d[7]) begin
			$display("serial transfer still running after %0d polls", n);
			errors++;
		end
		check_byte("SC done", d, 8'h7F);
		read_check("IF serial", ADDR_IF, 8'hE8);
		read_check("SB", ADDR_SB, 8'hFF);
		end_test("serial");

		// boot register
		read_check("FF50 fast boot", ADDR_BOOT, 8'h42);
		bus_write(ADDR_BOOT, 8'h11);  // colour mode disable value
		read_check("FF50 disabled", ADDR_BOOT, 8'hFF);
		end_test("boot");

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

// ==== gb_io_sva.sv ====
// ------------------------------------------------------------------------
// bound checks on the I/O top level: read strobe timing, irq masking
// and the quiet state coming out of reset
// ------------------------------------------------------------------------
`timescale 1ns/100ps

module gb_io_sva (
	input logic                clk_cpu,
	input logic                reset,
	input gb_io_pkg::cpu_bus_t bus,
	input logic                rdata_valid,
	input logic                irq,
	input gb_map_pkg::data_t   irq_vec
);
	import gb_map_pkg::*;
	import gb_io_pkg::*;

	irq_bits_t ie_seen; // IE as the bus last wrote it

	always_ff @(posedge clk_cpu) begin
		if (reset)
			ie_seen <= '0;
		else if (bus.wr && bus.addr == ADDR_IE)
			ie_seen <= bus.wdata[4:0];
	end

	// rdata_valid exactly one cycle after rd
	a_valid_after_rd: assert property (@(posedge clk_cpu) disable iff (reset)
		bus.rd |=> rdata_valid)
		else $error("rdata_valid missing one cycle after a read");

	a_no_stray_valid: assert property (@(posedge clk_cpu) disable iff (reset)
		!bus.rd |=> !rdata_valid)
		else $error("rdata_valid high without a read one cycle before");

	// nothing enabled, nothing raised
	a_irq_masked: assert property (@(posedge clk_cpu) disable iff (reset)
		(ie_seen == '0) |-> !irq)
		else $error("irq high while IE is zero");

	a_reset_quiet: assert property (@(posedge clk_cpu)
		reset |=> (!rdata_valid && !irq && irq_vec == IRQ_VEC_NONE))
		else $error("outputs active right after reset");

endmodule

bind gb_io_top gb_io_sva u_sva (
	.clk_cpu     (clk_cpu),
	.reset       (reset),
	.bus         (bus),
	.rdata_valid (rdata_valid),
	.irq         (irq),
	.irq_vec     (irq_vec)
);

// ==== gb_io_top.sv ====
// ------------------------------------------------------------------------
// console I/O and internal memory subsystem, cpu side replaced by a bus port
// ------------------------------------------------------------------------
`timescale 1ns/100ps

module gb_io_top (
	input  logic                 clk_cpu,
	input  logic                 reset,
	input  gb_io_pkg::cpu_bus_t  bus,
	input  logic                 irq_ack,
	input  logic [7:0]           joystick,  // active high buttons
	input  logic                 isgbc,
	input  logic                 fast_boot,
	input  gb_io_pkg::irq_bits_t ext_irq,
	output gb_map_pkg::data_t    rdata,
	output logic                 rdata_valid,
	output logic                 irq,       // active high
	output gb_map_pkg::data_t    irq_vec
);
	import gb_map_pkg::*;

	region_e sel;
	data_t   irq_rd;
	data_t   joy_rd;
	data_t   ser_rd;
	data_t   bank_rd;
	data_t   ram_rd;
	logic    serial_irq;
	logic    joy_irq;

	gb_bus_decode u_decode (
		.clk_cpu     (clk_cpu),
		.reset       (reset),
		.bus         (bus),
		.isgbc       (isgbc),
		.fast_boot   (fast_boot),
		.irq_rd      (irq_rd),
		.joy_rd      (joy_rd),
		.ser_rd      (ser_rd),
		.bank_rd     (bank_rd),
		.ram_rd      (ram_rd),
		.sel         (sel),
		.rdata       (rdata),
		.rdata_valid (rdata_valid)
	);

	gb_irq_ctrl u_irq (
		.clk_cpu    (clk_cpu),
		.reset      (reset),
		.bus        (bus),
		.sel        (sel),
		.ext_irq    (ext_irq),
		.serial_irq (serial_irq),
		.joy_irq    (joy_irq),
		.irq_ack    (irq_ack),
		.irq_rd     (irq_rd),
		.irq        (irq),
		.irq_vec    (irq_vec)
	);

	gb_joypad u_joy (
		.clk_cpu  (clk_cpu),
		.reset    (reset),
		.bus      (bus),
		.sel      (sel),
		.joystick (joystick),
		.joy_rd   (joy_rd),
		.joy_irq  (joy_irq)
	);

	gb_serial u_serial (
		.clk_cpu    (clk_cpu),
		.reset      (reset),
		.bus        (bus),
		.sel        (sel),
		.ser_rd     (ser_rd),
		.serial_irq (serial_irq)
	);

	gb_ram_ctrl u_ram (
		.clk_cpu (clk_cpu),
		.reset   (reset),
		.bus     (bus),
		.sel     (sel),
		.isgbc   (isgbc),
		.ram_rd  (ram_rd),
		.bank_rd (bank_rd)
	);

endmodule

// ==== gb_ram_ctrl.sv ====
// ------------------------------------------------------------------------
// banked 32k work ram with SVBK register, and the 127 byte zero page ram
// ------------------------------------------------------------------------
`timescale 1ns/100ps

module gb_ram_ctrl (
	input  logic                clk_cpu,
	input  logic                reset,
	input  gb_io_pkg::cpu_bus_t bus,
	input  gb_map_pkg::region_e sel,
	input  logic                isgbc,
	output gb_map_pkg::data_t   ram_rd,
	output gb_map_pkg::data_t   bank_rd
);
	import gb_map_pkg::*;

	data_t      wram [WRAM_DEPTH];
	data_t      zpram [ZP_DEPTH];
	wram_bank_t bank_q;    // SVBK, 1..7
	wram_bank_t bank_eff;
	wram_addr_t wram_addr;
	zp_addr_t   zp_addr;
	data_t      wram_q;
	data_t      zp_q;
	logic       zp_sel_q;  // which array the last access hit

	// ------------------------------------------------------------------------
	// bank register
	always_ff @(posedge clk_cpu) begin
		if (reset)
			bank_q <= wram_bank_t'(1);
		else if (sel == REG_SVBK && bus.wr) begin
			if (bus.wdata[2:0] == 3'd0)
				bank_q <= wram_bank_t'(1); // 0 maps to 1
			else
				bank_q <= bus.wdata[2:0];
		end
	end

	assign bank_rd = {5'h1F, bank_q};

	// classic mode only has 8k, upper half is bank 1
	assign bank_eff = isgbc ? bank_q : wram_bank_t'(1);

	// C000-CFFF bank 0, D000-DFFF switched
	assign wram_addr = bus.addr[12] ? {bank_eff, bus.addr[11:0]} : {3'd0, bus.addr[11:0]};
	assign zp_addr   = bus.addr[6:0]; // FF80..FFFE, FFFF is IE

	// ------------------------------------------------------------------------
	// arrays, read one cycle after the address
	always_ff @(posedge clk_cpu) begin
		if (sel == REG_WRAM && bus.wr)
			wram[wram_addr] <= bus.wdata;
		wram_q <= wram[wram_addr];
	end

	always_ff @(posedge clk_cpu) begin
		if (sel == REG_ZPRAM && bus.wr)
			zpram[zp_addr] <= bus.wdata;
		zp_q <= zpram[zp_addr];
	end

	always_ff @(posedge clk_cpu) begin
		if (reset)
			zp_sel_q <= 1'b0;
		else
			zp_sel_q <= (sel == REG_ZPRAM);
	end

	assign ram_rd = zp_sel_q ? zp_q : wram_q;

endmodule

// ==== gb_serial.sv ====
// ------------------------------------------------------------------------
// dummy serial port: SB / SC, internal clock bit countdown, done interrupt
// ------------------------------------------------------------------------
`timescale 1ns/100ps

module gb_serial (
	input  logic                clk_cpu,
	input  logic                reset,
	input  gb_io_pkg::cpu_bus_t bus,
	input  gb_map_pkg::region_e sel,
	output gb_map_pkg::data_t   ser_rd,
	output logic                serial_irq
);
	import gb_map_pkg::*;
	import gb_io_pkg::*;

	serial_state_e state;
	logic          sc_start; // SC bit 7, transfer running
	logic          sc_clk;   // SC bit 0, internal clock
	logic          sc_wr;
	ser_div_t      div_q;
	ser_cnt_t      bit_cnt;

	assign sc_wr = (sel == REG_SC) && bus.wr;

	// ------------------------------------------------------------------------
	// control
	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			state      <= SER_IDLE;
			sc_start   <= 1'b0;
			sc_clk     <= 1'b0;
			serial_irq <= 1'b0;
		end else begin
			serial_irq <= 1'b0;
			if (sc_wr) begin
				sc_start <= bus.wdata[7];
				sc_clk   <= bus.wdata[0];
				// external clock never arrives, so only internal shifts
				state    <= (bus.wdata[7] && bus.wdata[0]) ? SER_SHIFT : SER_IDLE;
			end else if (state == SER_SHIFT && bit_cnt == '0) begin
				sc_start   <= 1'b0; // done
				serial_irq <= 1'b1;
				state      <= SER_IDLE;
			end
		end
	end

	// divider and bit counter, loaded on every SC write
	always_ff @(posedge clk_cpu) begin
		if (sc_wr) begin
			div_q   <= SER_DIV_RELOAD;
			bit_cnt <= SER_BITS;
		end else if (state == SER_SHIFT) begin
			div_q <= div_q - ser_div_t'(1); // wraps back to 1FF
			if (div_q == '0)
				bit_cnt <= bit_cnt - ser_cnt_t'(1);
		end
	end

	// SB has no shifter behind it
	assign ser_rd = (sel == REG_SC) ? {sc_start, 6'h3F, sc_clk} : OPEN_BUS;

endmodule

// ==== gb_joypad.sv ====
// ------------------------------------------------------------------------
// joypad P1 register, button matrix and input falling-edge interrupt
// ------------------------------------------------------------------------
`timescale 1ns/100ps

module gb_joypad (
	input  logic                clk_cpu,
	input  logic                reset,
	input  gb_io_pkg::cpu_bus_t bus,
	input  gb_map_pkg::region_e sel,
	input  logic [7:0]          joystick,
	output gb_map_pkg::data_t   joy_rd,
	output logic                joy_irq
);
	import gb_map_pkg::*;

	logic [1:0] p1_sel;  // P15, P14, low selects the group
	logic [3:0] dpad_n;  // active low, masked
	logic [3:0] btn_n;
	logic [7:0] sync1;   // two stage synchroniser
	logic [7:0] sync2;
	logic [7:0] lines_q; // previous synchronised value

	assign dpad_n = ~joystick[3:0] | {4{p1_sel[0]}};
	assign btn_n  = ~joystick[7:4] | {4{p1_sel[1]}};

	always_ff @(posedge clk_cpu) begin
		if (reset)
			p1_sel <= 2'b00;
		else if (sel == REG_JOY && bus.wr)
			p1_sel <= bus.wdata[5:4];
	end

	assign joy_rd = {2'b11, p1_sel, dpad_n & btn_n};

	// lines idle high, so reset to ones
	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			sync1   <= '1;
			sync2   <= '1;
			lines_q <= '1;
		end else begin
			sync1   <= {dpad_n, btn_n};
			sync2   <= sync1;
			lines_q <= sync2;
		end
	end

	assign joy_irq = |(lines_q & ~sync2); // any line falling

endmodule

// ==== gb_irq_ctrl.sv ====
// ------------------------------------------------------------------------
// interrupt controller: IF / IE registers, priority vector, ack clearing
// ------------------------------------------------------------------------
`timescale 1ns/100ps

module gb_irq_ctrl (
	input  logic                 clk_cpu,
	input  logic                 reset,
	input  gb_io_pkg::cpu_bus_t  bus,
	input  gb_map_pkg::region_e  sel,
	input  gb_io_pkg::irq_bits_t ext_irq,
	input  logic                 serial_irq,
	input  logic                 joy_irq,
	input  logic                 irq_ack,
	output gb_map_pkg::data_t    irq_rd,
	output logic                 irq,
	output gb_map_pkg::data_t    irq_vec
);
	import gb_map_pkg::*;
	import gb_io_pkg::*;

	irq_bits_t if_r;     // flags
	irq_bits_t ie_r;     // enable mask
	irq_bits_t pending;
	irq_bits_t src_set;  // one cycle source pulses
	irq_bits_t ack_clr;  // the single bit an ack takes away
	irq_bits_t if_next;

	assign pending = if_r & ie_r;
	assign irq     = |pending; // no extra delay

	// sources, ext only drives vblank, lcdc and timer
	always_comb begin
		src_set             = '0;
		src_set[2:0]        = ext_irq[2:0];
		src_set[IRQ_SERIAL] = serial_irq;
		src_set[IRQ_JOYPAD] = joy_irq;
	end

	// priority, walk down so the lowest bit is left standing
	always_comb begin
		irq_vec = IRQ_VEC_NONE;
		ack_clr = '0;
		for (int i = IRQ_NUM - 1; i >= 0; i--) begin
			if (pending[i]) begin
				irq_vec    = IRQ_VEC_BASE + data_t'(i) * IRQ_VEC_STEP;
				ack_clr    = '0;
				ack_clr[i] = 1'b1;
			end
		end
	end

	always_comb begin
		if_next = if_r | src_set;
		if (irq_ack)
			if_next = if_next & ~ack_clr;
		if (sel == REG_IF && bus.wr)
			if_next = bus.wdata[4:0]; // cpu write has the last word
	end

	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			if_r <= '0;
			ie_r <= '0;
		end else begin
			if_r <= if_next;
			if (sel == REG_IE && bus.wr)
				ie_r <= bus.wdata[4:0];
		end
	end

	// unused top bits read 1 in IF, 0 in IE
	assign irq_rd = (sel == REG_IF) ? {3'b111, if_r} : {3'b000, ie_r};

endmodule

// ==== gb_bus_decode.sv ====
// ------------------------------------------------------------------------
// bus decode: address to region, boot rom disable / fast boot register
// and the registered read data mux
// ------------------------------------------------------------------------
`timescale 1ns/100ps

module gb_bus_decode (
	input  logic                clk_cpu,
	input  logic                reset,
	input  gb_io_pkg::cpu_bus_t bus,
	input  logic                isgbc,
	input  logic                fast_boot,
	input  gb_map_pkg::data_t   irq_rd,
	input  gb_map_pkg::data_t   joy_rd,
	input  gb_map_pkg::data_t   ser_rd,
	input  gb_map_pkg::data_t   bank_rd,
	input  gb_map_pkg::data_t   ram_rd,
	output gb_map_pkg::region_e sel,
	output gb_map_pkg::data_t   rdata,
	output logic                rdata_valid
);
	import gb_map_pkg::*;

	logic    boot_en;    // boot rom still mapped
	data_t   reg_byte;   // register read value, this cycle
	data_t   reg_byte_q;
	region_e region_q;   // region of the last read

	// ------------------------------------------------------------------------
	// address decode
	always_comb begin
		sel = REG_NONE;
		if (bus.addr >= ADDR_WRAM_BASE && bus.addr < ADDR_OAM_BASE)
			sel = REG_WRAM; // C000-DFFF plus echo
		else if (bus.addr >= ADDR_ZP_BASE && bus.addr != ADDR_IE)
			sel = REG_ZPRAM;
		else begin
			case (bus.addr)
				ADDR_JOY:  sel = REG_JOY;
				ADDR_SB:   sel = REG_SB;
				ADDR_SC:   sel = REG_SC;
				ADDR_IF:   sel = REG_IF;
				ADDR_IE:   sel = REG_IE;
				ADDR_BOOT: sel = REG_BOOT;
				ADDR_SVBK: sel = isgbc ? REG_SVBK : REG_NONE; // classic mode reads FF
				default:   sel = REG_NONE; // rom, cart ram, vram, oam ...
			endcase
		end
	end

	// boot rom disable, 11 in colour mode, bit 0 in classic mode
	always_ff @(posedge clk_cpu) begin
		if (reset)
			boot_en <= 1'b1;
		else if (sel == REG_BOOT && bus.wr) begin
			if ((isgbc && bus.wdata == 8'h11) || (!isgbc && bus.wdata[0]))
				boot_en <= 1'b0;
		end
	end

	// register read byte
	always_comb begin
		case (sel)
			REG_IF, REG_IE: reg_byte = irq_rd;
			REG_JOY:        reg_byte = joy_rd;
			REG_SB, REG_SC: reg_byte = ser_rd;
			REG_SVBK:       reg_byte = bank_rd;
			REG_BOOT:       reg_byte = (boot_en && fast_boot) ? FAST_BOOT_FLAG : OPEN_BUS;
			default:        reg_byte = OPEN_BUS;
		endcase
	end

	// ------------------------------------------------------------------------
	// read pipeline, one cycle like the ram
	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			rdata_valid <= 1'b0;
			region_q    <= REG_NONE;
		end else begin
			rdata_valid <= bus.rd;
			if (bus.rd)
				region_q <= sel;
		end
	end

	always_ff @(posedge clk_cpu) begin
		if (bus.rd)
			reg_byte_q <= reg_byte;
	end

	// ram byte comes straight from the synchronous arrays
	assign rdata = (region_q == REG_WRAM || region_q == REG_ZPRAM) ? ram_rd : reg_byte_q;

endmodule

// ==== gb_io_pkg.sv ====
// ------------------------------------------------------------------------
// I/O formats: cpu bus request, interrupt bits and vectors, serial port
// ------------------------------------------------------------------------

package gb_io_pkg;

	// one request word, rd or wr high for a single cycle
	typedef struct packed {
		gb_map_pkg::addr_t addr;
		gb_map_pkg::data_t wdata;
		logic              rd;
		logic              wr;
	} cpu_bus_t;

	// bit 0 vblank .. bit 4 joypad, bit 0 wins
	typedef logic [4:0] irq_bits_t;

	localparam int IRQ_NUM    = 5;
	localparam int IRQ_SERIAL = 3;
	localparam int IRQ_JOYPAD = 4;

	// rst vectors 40, 48, 50, 58, 60
	localparam gb_map_pkg::data_t IRQ_VEC_BASE = 8'h40;
	localparam gb_map_pkg::data_t IRQ_VEC_STEP = 8'h08;
	localparam gb_map_pkg::data_t IRQ_VEC_NONE = 8'h55; // nothing pending

	// ------------------------------------------------------------------------
	// dummy serial port
	typedef logic [8:0] ser_div_t;  // 8192 Hz shift clock divider
	typedef logic [3:0] ser_cnt_t;  // bits left

	localparam ser_div_t SER_DIV_RELOAD = 9'h1FF;
	localparam ser_cnt_t SER_BITS       = 4'd8;

	typedef enum logic {
		SER_IDLE,
		SER_SHIFT
	} serial_state_e;

endpackage

// ==== gb_map_pkg.sv ====
// ------------------------------------------------------------------------
// memory map of the console I/O subsystem
// address and data types, region codes and register addresses
// ------------------------------------------------------------------------

package gb_map_pkg;

	typedef logic [15:0] addr_t;      // cpu address
	typedef logic [7:0]  data_t;      // one data byte
	typedef logic [14:0] wram_addr_t; // {bank, offset[11:0]}
	typedef logic [6:0]  zp_addr_t;   // zero page offset
	typedef logic [2:0]  wram_bank_t; // SVBK bank number

	// region of the current access, kept with a read for the data mux
	typedef enum logic [3:0] {
		REG_NONE,
		REG_WRAM,
		REG_ZPRAM,
		REG_IF,
		REG_IE,
		REG_JOY,
		REG_SB,
		REG_SC,
		REG_SVBK,
		REG_BOOT
	} region_e;

	// ------------------------------------------------------------------------
	// register addresses
	localparam addr_t ADDR_JOY  = 16'hFF00; // P1
	localparam addr_t ADDR_SB   = 16'hFF01; // serial data
	localparam addr_t ADDR_SC   = 16'hFF02; // serial control
	localparam addr_t ADDR_IF   = 16'hFF0F;
	localparam addr_t ADDR_BOOT = 16'hFF50; // boot rom disable
	localparam addr_t ADDR_SVBK = 16'hFF70; // colour mode only
	localparam addr_t ADDR_IE   = 16'hFFFF;

	// memory windows
	localparam addr_t ADDR_WRAM_BASE = 16'hC000; // wram + echo up to FDFF
	localparam addr_t ADDR_OAM_BASE  = 16'hFE00; // end of echo, oam is gone
	localparam addr_t ADDR_ZP_BASE   = 16'hFF80;

	localparam int WRAM_DEPTH = 32768; // 8 banks of 4k
	localparam int ZP_DEPTH   = 127;   // FF80..FFFE

	localparam data_t FAST_BOOT_FLAG = 8'h42; // seen by the boot code at FF50
	localparam data_t OPEN_BUS       = 8'hFF;

endpackage
